//--- verilog/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN       64            // Width of the integer data path.
`define RESET_PC   64'h0         // First fetch address after reset.
`define DRAM_WORDS 256           // Doublewords held by the data RAM.

`define OPC_OP     7'b0110011    // Register-register ALU ops.
`define OPC_OP_IMM 7'b0010011    // Register-immediate ALU ops.
`define OPC_LUI    7'b0110111    // Load upper immediate.
`define OPC_LOAD   7'b0000011    // Loads of every size.
`define OPC_STORE  7'b0100011    // Stores of every size.
`define OPC_BRANCH 7'b1100011    // Conditional branches.
`define OPC_SYSTEM 7'b1110011    // EBREAK lives here.

`endif

//--- verilog/isaPkg.sv
`default_nettype none

package isaPkg;

  typedef logic [31:0] instrT;   // One 32-bit RV64I instruction.
  typedef logic [4:0]  regIdxT;  // Architectural register number.

  // Load/store size codes match funct3 directly, so the decoder can cast it.
  typedef enum logic [2:0] {
    opByte  = 3'b000,            // LB and SB.
    opHalf  = 3'b001,            // LH and SH.
    opWord  = 3'b010,            // LW and SW.
    opDword = 3'b011,            // LD and SD.
    opByteU = 3'b100,            // LBU, zero extended.
    opHalfU = 3'b101,            // LHU, zero extended.
    opWordU = 3'b110             // LWU, zero extended.
  } memOpT;

  // Source of the value written back into rd.
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,               // Adder result.
    wbImm  = 2'd1,               // U-format immediate, for LUI.
    wbLoad = 2'd2                // Extended data from the load path.
  } wbSelT;

endpackage

`default_nettype wire

//--- verilog/memPkg.sv
`default_nettype none

`include "rv_consts.svh"

package memPkg;

  typedef logic [`XLEN-1:0] dwordT;   // Data and address values.
  typedef logic [7:0]       byteMaskT; // One enable per byte lane.
  typedef logic [2:0]       byteOffT;  // Byte position inside a doubleword.
  typedef logic [7:0]       wordAddrT; // Doubleword index into the data RAM.

endpackage

`default_nettype wire

//--- verilog/coreRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module coreRegFile (
  input  wire               clk,
  input  wire               rst,
  input  wire isaPkg::regIdxT rs1,
  input  wire isaPkg::regIdxT rs2,
  input  wire isaPkg::regIdxT rd,
  input  wire               we,
  input  wire memPkg::dwordT  wdata,
  output memPkg::dwordT     rdata1,
  output memPkg::dwordT     rdata2,
  input  wire isaPkg::regIdxT dbgIdx,
  output memPkg::dwordT     dbgData,
  output logic              status
);
  import isaPkg::*;
  import memPkg::*;

  dwordT regFile [32];                                  // x0 is never written.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) regFile[i] <= '0;    // Whole file starts cleared.
    end else if (we && (rd != 5'd0)) begin
      regFile[rd] <= wdata;                             // Writes to x0 are dropped.
    end
  end

  assign rdata1  = (rs1 == 5'd0) ? '0 : regFile[rs1];   // x0 always reads as zero.
  assign rdata2  = (rs2 == 5'd0) ? '0 : regFile[rs2];   // Same rule for the second port.
  assign dbgData = (dbgIdx == 5'd0) ? '0 : regFile[dbgIdx]; // Debug peek for the testbench.
  assign status  = regFile[10][0];                      // Fixed tap on bit 0 of a0.

endmodule

`default_nettype wire

//--- verilog/coreDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module coreDecoder (
  input  wire isaPkg::instrT instr,
  output isaPkg::regIdxT   rs1,
  output isaPkg::regIdxT   rs2,
  output isaPkg::regIdxT   rd,
  output memPkg::dwordT    imm,
  output logic             aluSub,
  output logic             aluUseImm,
  output logic             regWe,
  output isaPkg::wbSelT    wbSel,
  output isaPkg::memOpT    memOp,
  output logic             memRd,
  output logic             memWr,
  output logic             isBranch,
  output logic             branchNe,
  output logic             isHalt,
  output logic             illegal
);
  import isaPkg::*;
  import memPkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];                 // Register fields sit at fixed spots.
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign memOp  = memOpT'(funct3);              // Size code is funct3 itself.

  always_comb begin
    imm       = '0;                             // Controls default to a harmless no-op.
    aluSub    = 1'b0;
    aluUseImm = 1'b0;
    regWe     = 1'b0;
    wbSel     = wbAlu;
    memRd     = 1'b0;
    memWr     = 1'b0;
    isBranch  = 1'b0;
    branchNe  = 1'b0;
    isHalt    = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      `OPC_OP: begin
        if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
          regWe  = 1'b1;                        // ADD or SUB.
          aluSub = funct7[5];                   // Bit 30 selects subtraction.
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          regWe     = 1'b1;                     // ADDI only.
          aluUseImm = 1'b1;
          imm       = {{52{instr[31]}}, instr[31:20]};
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_LUI: begin
        regWe = 1'b1;
        wbSel = wbImm;                          // Immediate goes straight to rd.
        imm   = {{32{instr[31]}}, instr[31:12], 12'b0};
      end
      `OPC_LOAD: begin
        if (funct3 != 3'b111) begin             // No unsigned doubleword load.
          regWe     = 1'b1;
          memRd     = 1'b1;
          wbSel     = wbLoad;
          aluUseImm = 1'b1;                     // Address is rs1 plus the I immediate.
          imm       = {{52{instr[31]}}, instr[31:20]};
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_STORE: begin
        if (!funct3[2]) begin                   // Stores have no unsigned forms.
          memWr     = 1'b1;
          aluUseImm = 1'b1;
          imm       = {{52{instr[31]}}, instr[31:25], instr[11:7]};
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin         // BEQ or BNE.
          isBranch = 1'b1;
          branchNe = funct3[0];
          imm      = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_SYSTEM: begin
        if (instr == 32'h0010_0073) isHalt = 1'b1; // EBREAK is the only system op kept.
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;                  // Anything else is outside the subset.
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/memLoadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module memLoadStoreUnit (
  input  wire memPkg::dwordT  addr,
  input  wire isaPkg::memOpT  memOp,
  input  wire                 memRd,
  input  wire                 memWr,
  input  wire memPkg::dwordT  storeData,
  output memPkg::dwordT       loadData,
  output memPkg::wordAddrT    ramAddr,
  output logic                ramWe,
  output memPkg::byteMaskT    ramMask,
  output memPkg::dwordT       ramWdata,
  input  wire memPkg::dwordT  ramRdata
);
  import isaPkg::*;
  import memPkg::*;

  byteOffT     byteOff;
  logic [7:0]  laneByte;
  logic [15:0] laneHalf;
  logic [31:0] laneWord;
  dwordT       extended;

  assign byteOff = addr[2:0];                    // Lane position inside the doubleword.
  assign ramAddr = addr[10:3];                   // Doubleword index, upper bits ignored.
  assign ramWe   = memWr;

  assign laneByte = ramRdata[byteOff*8 +: 8];    // Any of the eight bytes.
  assign laneHalf = ramRdata[byteOff[2:1]*16 +: 16]; // Offset bit 0 is dropped.
  assign laneWord = ramRdata[byteOff[2]*32 +: 32];   // Lower or upper word.

  always_comb begin
    case (memOp)
      opByte:  extended = {{56{laneByte[7]}}, laneByte};
      opByteU: extended = {56'b0, laneByte};
      opHalf:  extended = {{48{laneHalf[15]}}, laneHalf};
      opHalfU: extended = {48'b0, laneHalf};
      opWord:  extended = {{32{laneWord[31]}}, laneWord};
      opWordU: extended = {32'b0, laneWord};
      default: extended = ramRdata;              // LD passes through untouched.
    endcase
  end

  assign loadData = memRd ? extended : '0;       // Idle cycles read back zero.

  always_comb begin
    case (memOp)
      opByte: begin
        ramWdata = {8{storeData[7:0]}};          // Same byte in every lane.
        ramMask  = 8'b0000_0001 << byteOff;
      end
      opHalf: begin
        ramWdata = {4{storeData[15:0]}};
        ramMask  = 8'b0000_0011 << {byteOff[2:1], 1'b0}; // Two adjacent lanes.
      end
      opWord: begin
        ramWdata = {2{storeData[31:0]}};
        ramMask  = byteOff[2] ? 8'hf0 : 8'h0f;   // Upper or lower four lanes.
      end
      default: begin
        ramWdata = storeData;                    // SD writes the whole doubleword.
        ramMask  = 8'hff;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module dataRam (
  input  wire                  clk,
  input  wire memPkg::wordAddrT addr,
  input  wire                  we,
  input  wire memPkg::byteMaskT mask,
  input  wire memPkg::dwordT    wdata,
  output memPkg::dwordT         rdata
);
  import memPkg::*;

  dwordT mem [`DRAM_WORDS];                       // Contents are undefined until written.

  assign rdata = mem[addr];                       // Read is combinational.

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 8; i++) begin
        if (mask[i]) mem[addr][i*8 +: 8] <= wdata[i*8 +: 8]; // Unmasked bytes keep their value.
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/coreCpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module coreCpu (
  input  wire                 clk,
  input  wire                 rst,
  input  wire isaPkg::instrT  instr,
  output memPkg::dwordT       pc,
  output memPkg::dwordT       addr,
  output isaPkg::memOpT       memOp,
  output logic                memRd,
  output logic                memWr,
  output memPkg::dwordT       storeData,
  input  wire memPkg::dwordT  loadData,
  input  wire isaPkg::regIdxT dbgIdx,
  output memPkg::dwordT       dbgData,
  output logic                status,
  output logic                done,
  output logic                error
);
  import isaPkg::*;
  import memPkg::*;

  regIdxT rs1, rs2, rd;
  dwordT  imm, rdata1, rdata2, operandB, aluResult, wbData, nextPc;
  logic   aluSub, aluUseImm, decRegWe, decMemRd, decMemWr;
  logic   isBranch, branchNe, isHalt, illegal;
  logic   halted, active, branchTaken;
  wbSelT  wbSel;

  coreDecoder u_coreDecoder (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .aluSub(aluSub), .aluUseImm(aluUseImm), .regWe(decRegWe), .wbSel(wbSel),
    .memOp(memOp), .memRd(decMemRd), .memWr(decMemWr), .isBranch(isBranch),
    .branchNe(branchNe), .isHalt(isHalt), .illegal(illegal)
  );

  coreRegFile u_coreRegFile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .we(decRegWe && active), .wdata(wbData), .rdata1(rdata1), .rdata2(rdata2),
    .dbgIdx(dbgIdx), .dbgData(dbgData), .status(status)
  );

  assign halted = done || error;                         // Sticky until the next reset.
  assign active = !halted && !rst && !isHalt && !illegal; // Gate for every side effect.

  assign operandB  = aluUseImm ? imm : rdata2;           // Immediate for ADDI and addresses.
  assign aluResult = aluSub ? rdata1 - operandB : rdata1 + operandB;
  assign addr      = aluResult;                          // Loads and stores reuse the adder.
  assign storeData = rdata2;                             // Store value always comes from rs2.
  assign memRd     = decMemRd && active;
  assign memWr     = decMemWr && active;                 // One cycle, tied to this instruction.

  assign branchTaken = isBranch && ((rdata1 == rdata2) != branchNe); // BNE inverts BEQ.
  assign nextPc      = branchTaken ? pc + imm : pc + 64'd4;

  always_comb begin
    case (wbSel)
      wbImm:   wbData = imm;                             // LUI result.
      wbLoad:  wbData = loadData;                        // Already extended by the LSU.
      default: wbData = aluResult;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= `RESET_PC;
      done  <= 1'b0;
      error <= 1'b0;
    end else if (!halted) begin
      if (isHalt) done <= 1'b1;                          // pc stays on the EBREAK.
      else if (illegal) error <= 1'b1;                   // pc stays on the bad encoding.
      else pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

//--- verilog/socTop.sv
`timescale 1ns/1ps
`default_nettype none

module socTop (
  input  wire                 clk,
  input  wire                 rst,
  output memPkg::dwordT       pc,
  input  wire memPkg::dwordT  instrData,
  input  wire isaPkg::regIdxT dbgIdx,
  output memPkg::dwordT       dbgData,
  output logic                done,
  output logic                error,
  output logic                status
);
  import isaPkg::*;
  import memPkg::*;

  instrT    instr;
  dwordT    addr, storeData, loadData, ramWdata, ramRdata;
  memOpT    memOp;
  logic     memRd, memWr, ramWe;
  wordAddrT ramAddr;
  byteMaskT ramMask;

  assign instr = pc[2] ? instrData[63:32] : instrData[31:0]; // Fetch returns two instructions.

  coreCpu u_coreCpu (
    .clk(clk), .rst(rst), .instr(instr), .pc(pc), .addr(addr), .memOp(memOp),
    .memRd(memRd), .memWr(memWr), .storeData(storeData), .loadData(loadData),
    .dbgIdx(dbgIdx), .dbgData(dbgData), .status(status), .done(done), .error(error)
  );

  memLoadStoreUnit u_memLoadStoreUnit (
    .addr(addr), .memOp(memOp), .memRd(memRd), .memWr(memWr), .storeData(storeData),
    .loadData(loadData), .ramAddr(ramAddr), .ramWe(ramWe), .ramMask(ramMask),
    .ramWdata(ramWdata), .ramRdata(ramRdata)
  );

  dataRam u_dataRam (
    .clk(clk), .addr(ramAddr), .we(ramWe), .mask(ramMask),
    .wdata(ramWdata), .rdata(ramRdata)
  );

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk
);

  initial clk = 1'b0;                      // Starts low, so the first rising edge is at 5 ns.

  always #5 clk = ~clk;                    // 10 ns period.

endmodule

`default_nettype wire

//--- verif/tbSocTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tbSocTop;

  localparam int MAX_CYCLES = 2000;          // Nine runs of roughly 120 cycles each, with margin.
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic        clk;
  logic        rst;
  logic [63:0] pc;
  logic [63:0] instrData;
  logic [4:0]  dbgIdx;
  logic [63:0] dbgData;
  logic        done;
  logic        error;
  logic        status;
  logic [63:0] rom [32];                     // Instruction ROM, two instructions per entry.
  logic [31:0] prog [$];                     // Program being assembled.
  logic [63:0] shadow [32];                  // Predicted architectural registers.
  logic [7:0]  refMem [2048];                // Predicted data RAM contents, byte by byte.
  logic [31:0] lcgState = 32'd90707;
  int          errors = 0;
  int          cycles = 0;

  tbClock u_tbClock (.clk(clk));

  socTop u_socTop (
    .clk(clk), .rst(rst), .pc(pc), .instrData(instrData), .dbgIdx(dbgIdx),
    .dbgData(dbgData), .done(done), .error(error), .status(status)
  );

  assign instrData = rom[pc[7:3]];           // The ROM answers the pc without a clock.

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int lcgImm();
    return int'(lcgNext() >> 20) - 2048;      // Spread over the whole 12-bit signed range.
  endfunction

  function automatic logic [31:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                       input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] encS(input logic [2:0] f3, input int rs1, input int rs2,
                                       input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
  endfunction

  function automatic logic [31:0] encBranch(input logic [2:0] f3, input int rs1, input int rs2,
                                            input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  // Little-endian lane read, sign-extended unless funct3 bit 2 asks for zero extension.
  function automatic logic [63:0] modelLoad(input logic [63:0] addr, input logic [2:0] f3);
    int          size;
    logic [63:0] v;
    size = 1 << f3[1:0];
    v    = '0;
    for (int i = 0; i < size; i++) v[i*8 +: 8] = refMem[addr[10:0] + i];
    if (!f3[2] && size < 8 && v[size*8-1]) v = v | (~64'd0 << (size*8));
    return v;
  endfunction

  task automatic writeShadow(input int rd, input logic [63:0] value);
    if (rd != 0) shadow[rd] = value;         // x0 never changes.
  endtask

  task automatic startProgram();
    prog.delete();
    for (int r = 0; r < 32; r++) shadow[r] = '0; // Reset clears the register file.
  endtask

  task automatic emitAddi(input int rd, input int rs1, input int imm);
    prog.push_back(encI(`OPC_OP_IMM, 3'b000, rd, rs1, imm));
    writeShadow(rd, shadow[rs1] + longint'(imm));
  endtask

  task automatic emitAdd(input int rd, input int rs1, input int rs2);
    prog.push_back(encR(7'b0000000, 3'b000, rd, rs1, rs2));
    writeShadow(rd, shadow[rs1] + shadow[rs2]);
  endtask

  task automatic emitSub(input int rd, input int rs1, input int rs2);
    prog.push_back(encR(7'b0100000, 3'b000, rd, rs1, rs2));
    writeShadow(rd, shadow[rs1] - shadow[rs2]);
  endtask

  task automatic emitLui(input int rd, input int imm20);
    prog.push_back({imm20[19:0], rd[4:0], `OPC_LUI});
    writeShadow(rd, longint'(int'(imm20 << 12))); // Upper 32 bits follow bit 31.
  endtask

  task automatic loadConst(input int rd, input logic [31:0] value);
    int lo;
    lo = int'(value[11:0]);
    if (lo >= 2048) lo -= 4096;              // ADDI sign-extends, so LUI takes the carry.
    emitLui(rd, int'((value + 32'h800) >> 12));
    emitAddi(rd, rd, lo);
  endtask

  task automatic emitLoad(input logic [2:0] f3, input int rd, input int rs1, input int imm);
    prog.push_back(encI(`OPC_LOAD, f3, rd, rs1, imm));
    writeShadow(rd, modelLoad(shadow[rs1] + longint'(imm), f3));
  endtask

  task automatic emitStore(input logic [2:0] f3, input int rs2, input int rs1, input int imm);
    logic [63:0] addr;
    addr = shadow[rs1] + longint'(imm);
    prog.push_back(encS(f3, rs1, rs2, imm));
    for (int i = 0; i < (1 << f3[1:0]); i++) refMem[addr[10:0] + i] = shadow[rs2][i*8 +: 8];
  endtask

  task automatic loadRom();
    for (int i = 0; i < 64; i++) begin      // Unused slots hold 0, which the core rejects.
      rom[i/2][(i%2)*32 +: 32] = (i < prog.size()) ? prog[i] : 32'h0;
    end
  endtask

  task automatic runProgram(input string name, input logic expectDone);
    loadRom();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;                           // First instruction executes in this cycle.
    while (!(done || error)) begin
      @(posedge clk);
      #1;
    end
    if (done !== expectDone || error !== !expectDone) begin
      $display("%s: the core halted the wrong way, done=%0b error=%0b", name, done, error);
      errors++;
    end
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic readReg(input int idx, output logic [63:0] value);
    @(posedge clk);
    #1 dbgIdx = 5'(idx);
    #1 value = dbgData;                      // Debug port is combinational.
  endtask

  task automatic checkRegs(input string name);
    logic [63:0] value;
    for (int r = 0; r < 32; r++) begin
      readReg(r, value);
      checkValue($sformatf("%s x%0d", name, r), shadow[r], value);
    end
  endtask

  task automatic storeMasks();
    startProgram();
    emitAddi(1, 0, 256);                     // Four doublewords from 0x100.
    loadConst(6, lcgNext());
    for (int d = 0; d < 4; d++) emitStore(3'd3, 6, 1, d*8); // Prefill before partial stores.
    loadConst(5, lcgNext());
    for (int o = 0; o < 8; o++) begin
      emitAddi(5, 5, lcgImm());
      emitStore(3'd0, 5, 1, o);
    end
    for (int o = 0; o < 8; o += 2) begin
      emitAddi(5, 5, lcgImm());
      emitStore(3'd1, 5, 1, 8 + o);
    end
    for (int o = 0; o < 8; o += 4) begin
      emitAddi(5, 5, lcgImm());
      emitStore(3'd2, 5, 1, 16 + o);
    end
    emitAddi(5, 5, lcgImm());
    emitStore(3'd3, 5, 1, 24);
    for (int d = 0; d < 4; d++) emitLoad(3'd3, 10 + d, 1, d*8);
    prog.push_back(EBREAK);
    runProgram("storeMasks", 1'b1);
    checkRegs("storeMasks");
  endtask

  task automatic loadExtraction();
    int rd;
    startProgram();
    emitAddi(1, 0, 512);
    loadConst(6, 32'hF28A_7C13);             // Mixed signs across the byte lanes.
    emitStore(3'd2, 6, 1, 0);
    loadConst(6, 32'h5E93_C461);
    emitStore(3'd2, 6, 1, 4);
    rd = 2;
    for (int f = 0; f < 7; f++) begin        // LB, LH, LW, LD, LBU, LHU, LWU.
      for (int o = 0; o < 8; o += 1 << (f % 4)) begin
        emitLoad(3'(f), rd, 1, o);
        rd = (rd == 5) ? 7 : rd + 1;         // x1 and x6 hold base and data.
      end
    end
    prog.push_back(EBREAK);
    runProgram("loadExtraction", 1'b1);
    checkRegs("loadExtraction");
  endtask

  task automatic aluAndLui();
    startProgram();
    emitAddi(1, 0, -5);
    emitAddi(2, 0, 2047);
    emitAdd(3, 1, 2);
    emitSub(4, 1, 2);
    emitLui(5, 32'h80000);                   // Sign bit set, so the upper word fills with ones.
    emitSub(6, 0, 5);
    emitAdd(7, 5, 5);                        // Wraps modulo 2^64.
    emitSub(8, 2, 1);
    emitAddi(0, 0, 5);
    emitAdd(0, 1, 2);                        // x0 must ignore both writes.
    emitAddi(9, 0, -2048);
    emitSub(12, 0, 1);
    emitAdd(13, 7, 7);
    loadConst(11, lcgNext());
    prog.push_back(EBREAK);
    runProgram("aluAndLui", 1'b1);
    checkRegs("aluAndLui");
  endtask

  task automatic branchPaths();
    startProgram();
    emitAddi(1, 0, 1);
    emitAddi(2, 0, 1);
    emitAddi(3, 0, 2);
    prog.push_back(encBranch(3'b000, 1, 2, 8)); // BEQ taken.
    prog.push_back(encI(`OPC_OP_IMM, 3'b000, 10, 0, 1));
    emitAddi(11, 0, 1);
    prog.push_back(encBranch(3'b000, 1, 3, 8)); // BEQ falls through.
    emitAddi(12, 0, 1);
    emitAddi(13, 0, 1);
    prog.push_back(encBranch(3'b001, 1, 3, 8)); // BNE taken.
    prog.push_back(encI(`OPC_OP_IMM, 3'b000, 14, 0, 1));
    emitAddi(15, 0, 1);
    prog.push_back(encBranch(3'b001, 1, 2, 8)); // BNE falls through.
    emitAddi(16, 0, 1);
    emitAddi(17, 0, 1);
    prog.push_back(EBREAK);
    runProgram("branchPaths", 1'b1);
    checkRegs("branchPaths");
  endtask

  task automatic haltBehavior(input int value);
    logic [63:0] pcHeld;
    startProgram();
    emitAddi(10, 0, value);
    emitAddi(11, 10, value);
    prog.push_back(EBREAK);
    runProgram("haltBehavior", 1'b1);
    checkRegs("haltBehavior");
    checkValue("haltBehavior status", 64'(shadow[10][0]), 64'(status));
    checkValue("haltBehavior pc", 64'd8, pc);   // pc rests on the EBREAK.
    pcHeld = pc;
    repeat (10) @(posedge clk);
    #1 checkValue("haltBehavior pc held", pcHeld, pc);
  endtask

  task automatic illegalOpcode();
    logic [63:0] saved;
    logic [63:0] value;
    startProgram();
    emitAddi(1, 0, 768);
    loadConst(5, lcgNext());
    emitStore(3'd3, 5, 1, 0);
    prog.push_back(EBREAK);
    runProgram("illegalOpcode setup", 1'b1);
    saved = modelLoad(64'd768, 3'd3);
    startProgram();
    emitAddi(1, 0, 768);
    loadConst(6, lcgNext());
    prog.push_back(encR(7'b0000000, 3'b100, 7, 1, 6)); // XOR is outside the subset.
    prog.push_back(encS(3'b011, 1, 6, 0));   // Must never reach the RAM.
    prog.push_back(EBREAK);
    runProgram("illegalOpcode", 1'b0);
    checkRegs("illegalOpcode");
    checkValue("illegalOpcode pc", 64'd12, pc);
    startProgram();
    emitAddi(1, 0, 768);
    emitLoad(3'd3, 7, 1, 0);
    prog.push_back(EBREAK);
    runProgram("illegalOpcode readback", 1'b1);
    readReg(7, value);
    checkValue("illegalOpcode readback", saved, value);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    rst    = 1'b1;
    dbgIdx = '0;
    storeMasks();
    loadExtraction();
    aluAndLui();
    branchPaths();
    haltBehavior(1);                         // status high.
    haltBehavior(2);                         // status low.
    illegalOpcode();
    $display("Errors: %0d after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/isaPkg.sv
verilog/memPkg.sv
verilog/coreRegFile.sv
verilog/coreDecoder.sv
verilog/memLoadStoreUnit.sv
verilog/dataRam.sv
verilog/coreCpu.sv
verilog/socTop.sv
verif/tbClock.sv
verif/tbSocTop.sv

//--- Bender.yml
package:
  name: rv64_lsu_soc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isaPkg.sv
      - verilog/memPkg.sv
      - verilog/coreRegFile.sv
      - verilog/coreDecoder.sv
      - verilog/memLoadStoreUnit.sv
      - verilog/dataRam.sv
      - verilog/coreCpu.sv
      - verilog/socTop.sv
      - target: test
        files:
          - verif/tbClock.sv
          - verif/tbSocTop.sv
